// File: all.f
logic/core_pkg.sv
logic/mem_pkg.sv
logic/credit_fifo.sv
logic/load_queue.sv
logic/dmem_bank.sv
logic/lsu_top.sv
verif/clk_gen.sv
verif/lsu_tb.sv

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

    // Datapath width for both data and addresses
    localparam int WORD_SIZE = 32;

    localparam int NUM_PHYS_REGS = 64;

    typedef logic [$clog2(NUM_PHYS_REGS)-1:0] preg_t;

    typedef enum logic [1:0] {
        UOP_LOAD  = 2'd0,
        UOP_STORE = 2'd1,
        UOP_ALU   = 2'd2,
        UOP_NOP   = 2'd3
    } uopcode_t;

    // Uop as handed over by the ROB at issue
    typedef struct packed {
        logic                 valid;
        uopcode_t             uopcode;
        logic [WORD_SIZE-1:0] r1_val;
        logic [WORD_SIZE-1:0] r2_val;
        preg_t                dest_reg_phys;
    } rob_issue_t;

    // Physical register file write port
    typedef struct packed {
        logic                 en;
        preg_t                index;
        logic [WORD_SIZE-1:0] data;
    } reg_write_t;

endpackage

`default_nettype wire

// File: logic/credit_fifo.sv
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  wire logic     clk_in,
    input  wire logic     rst_N_in,
    input  wire logic     flush_in,
    input  wire logic     push,
    input  wire payload_t push_data,
    output logic          credit,
    output logic          head_valid,
    output payload_t      head_data,
    input  wire logic     pop
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic             credit_q;
    logic             do_push;
    logic             do_pop;

    assign head_valid = (count != '0);
    assign head_data  = mem[rd_ptr];
    assign do_pop     = pop && head_valid;
    assign do_push    = push && (count < (PTR_W + 1)'(DEPTH));

    // Pulses in flight are not returned across a flush
    assign credit = credit_q && !flush_in;

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            credit_q <= 1'b0;
        end else if (flush_in) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            credit_q <= 1'b0;
        end else begin
            // One credit back per entry popped
            credit_q <= do_pop;
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/dmem_bank.sv
`default_nettype none

module dmem_bank import core_pkg::*, mem_pkg::*; (
    input  wire logic     clk_in,
    input  wire logic     rst_N_in,
    input  wire logic     req_valid,
    input  wire mem_req_t req_data,
    output logic          req_pop,
    output mem_resp_t     resp
);

    typedef enum logic {
        BANK_IDLE,
        BANK_BUSY
    } bank_state_t;

    bank_state_t           state;
    logic [WORD_SIZE-1:0]  words [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] rd_idx;
    lq_tag_t               rd_tag;
    logic                  resp_valid_q;
    logic [WORD_SIZE-1:0]  resp_data_q;
    lq_tag_t               resp_tag_q;

    // Only takes a new request when idle
    assign req_pop = (state == BANK_IDLE) && req_valid;

    // Contents loaded once from the fixed rule
    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                words[i] <= dmem_word(i);
            end
        end
    end

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            state        <= BANK_IDLE;
            resp_valid_q <= 1'b0;
        end else begin
            // Response is valid for exactly one cycle
            resp_valid_q <= (state == BANK_BUSY);
            case (state)
                BANK_IDLE: begin
                    if (req_valid) begin
                        state <= BANK_BUSY;
                    end
                end
                BANK_BUSY: state <= BANK_IDLE;
                default:   state <= BANK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (req_pop) begin
            rd_idx <= req_data.addr[DMEM_IDX_W+1:2];
            rd_tag <= req_data.tag;
        end
        if (state == BANK_BUSY) begin
            resp_data_q <= words[rd_idx];
            resp_tag_q  <= rd_tag;
        end
    end

    always_comb begin
        resp.valid = resp_valid_q;
        resp.data  = resp_data_q;
        resp.tag   = resp_tag_q;
    end

endmodule

`default_nettype wire

// File: logic/load_queue.sv
`default_nettype none

module load_queue import core_pkg::*, mem_pkg::*; (
    input  wire logic       clk_in,
    input  wire logic       rst_N_in,
    input  wire logic       flush_in,
    input  wire rob_issue_t issue_head,
    input  wire logic       issue_head_valid,
    output logic            issue_pop,
    output logic            req_push,
    output mem_req_t        req_data,
    input  wire logic       req_credit,
    input  wire mem_resp_t  mem_resp,
    output reg_write_t      reg_wr_out
);

    typedef struct packed {
        logic [WORD_SIZE-1:0] addr;
        preg_t                dest;
    } lq_entry_t;

    lq_entry_t                      entries [LQ_SIZE];
    logic [LQ_SIZE-1:0]             entry_valid;
    lq_tag_t                        alloc_ptr;
    lq_tag_t                        req_tag_q;
    logic [$clog2(REQ_DEPTH+1)-1:0] req_credits;
    logic                           is_load;
    logic                           alloc;
    logic                           drop;
    logic                           resp_hit;

    assign is_load = (issue_head.uopcode == UOP_LOAD);

    // Needs a free slot and a request buffer credit
    assign alloc = issue_head_valid && is_load && !entry_valid[alloc_ptr]
                   && (req_credits != '0) && !flush_in;

    // Anything that is not a load is discarded
    assign drop = issue_head_valid && !is_load && !flush_in;

    assign issue_pop = alloc || drop;

    // Responses to flushed slots are dropped, also in the flush cycle itself
    assign resp_hit = mem_resp.valid && entry_valid[mem_resp.tag] && !flush_in;

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            entry_valid <= '0;
            alloc_ptr   <= '0;
            req_push    <= 1'b0;
            req_credits <= ($clog2(REQ_DEPTH + 1))'(REQ_DEPTH);
        end else if (flush_in) begin
            entry_valid <= '0;
            alloc_ptr   <= '0;
            req_push    <= 1'b0;
            req_credits <= ($clog2(REQ_DEPTH + 1))'(REQ_DEPTH);
        end else begin
            req_push <= alloc;
            if (resp_hit) begin
                entry_valid[mem_resp.tag] <= 1'b0;
            end
            if (alloc) begin
                entry_valid[alloc_ptr] <= 1'b1;
                alloc_ptr              <= alloc_ptr + 1'b1;
            end
            case ({alloc, req_credit})
                2'b10:   req_credits <= req_credits - 1'b1;
                2'b01:   req_credits <= req_credits + 1'b1;
                default: req_credits <= req_credits;
            endcase
        end
    end

    // Address formed at allocation
    always_ff @(posedge clk_in) begin
        if (alloc) begin
            entries[alloc_ptr].addr <= issue_head.r1_val + issue_head.r2_val;
            entries[alloc_ptr].dest <= issue_head.dest_reg_phys;
            req_tag_q               <= alloc_ptr;
        end
    end

    // Request goes out the cycle after allocation
    assign req_data.addr = entries[req_tag_q].addr;
    assign req_data.tag  = req_tag_q;

    always_comb begin
        reg_wr_out = '0;
        if (resp_hit) begin
            reg_wr_out.en    = 1'b1;
            reg_wr_out.index = entries[mem_resp.tag].dest;
            reg_wr_out.data  = mem_resp.data;
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
`default_nettype none

module lsu_top import core_pkg::*, mem_pkg::*; (
    input  wire logic       clk_in,
    input  wire logic       rst_N_in,
    input  wire logic       flush_in,
    input  wire rob_issue_t issue_in,
    output logic            issue_credit,
    output reg_write_t      reg_wr_out
);

    rob_issue_t issue_head;
    logic       issue_head_valid;
    logic       issue_pop;
    mem_req_t   req_data;
    mem_req_t   req_head;
    logic       req_push;
    logic       req_credit;
    logic       req_head_valid;
    logic       req_pop;
    mem_resp_t  mem_resp;

    // Issue buffer between ROB and load queue
    credit_fifo #(
        .payload_t (rob_issue_t),
        .DEPTH     (ISSUE_DEPTH)
    ) u_issue_fifo (
        .clk_in     (clk_in),
        .rst_N_in   (rst_N_in),
        .flush_in   (flush_in),
        .push       (issue_in.valid),
        .push_data  (issue_in),
        .credit     (issue_credit),
        .head_valid (issue_head_valid),
        .head_data  (issue_head),
        .pop        (issue_pop)
    );

    load_queue u_load_queue (
        .clk_in           (clk_in),
        .rst_N_in         (rst_N_in),
        .flush_in         (flush_in),
        .issue_head       (issue_head),
        .issue_head_valid (issue_head_valid),
        .issue_pop        (issue_pop),
        .req_push         (req_push),
        .req_data         (req_data),
        .req_credit       (req_credit),
        .mem_resp         (mem_resp),
        .reg_wr_out       (reg_wr_out)
    );

    // Request buffer absorbs the slow bank
    credit_fifo #(
        .payload_t (mem_req_t),
        .DEPTH     (REQ_DEPTH)
    ) u_req_fifo (
        .clk_in     (clk_in),
        .rst_N_in   (rst_N_in),
        .flush_in   (flush_in),
        .push       (req_push),
        .push_data  (req_data),
        .credit     (req_credit),
        .head_valid (req_head_valid),
        .head_data  (req_head),
        .pop        (req_pop)
    );

    dmem_bank u_dmem_bank (
        .clk_in    (clk_in),
        .rst_N_in  (rst_N_in),
        .req_valid (req_head_valid),
        .req_data  (req_head),
        .req_pop   (req_pop),
        .resp      (mem_resp)
    );

endmodule

`default_nettype wire

// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    import core_pkg::*;

    localparam int LQ_SIZE     = 8;
    localparam int ISSUE_DEPTH = 4;
    localparam int REQ_DEPTH   = 4;

    // Bank geometry, word index taken from addr[9:2]
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

    // Multiplier for the bank content rule
    localparam int unsigned DMEM_MULT = 32'h9E3779B9;

    typedef logic [$clog2(LQ_SIZE)-1:0] lq_tag_t;

    typedef struct packed {
        logic [WORD_SIZE-1:0] addr;
        lq_tag_t              tag;
    } mem_req_t;

    typedef struct packed {
        logic                 valid;
        logic [WORD_SIZE-1:0] data;
        lq_tag_t              tag;
    } mem_resp_t;

    // Word content, index times the constant, wraps at 32 bits
    function automatic logic [WORD_SIZE-1:0] dmem_word(input int unsigned idx);
        return WORD_SIZE'(idx * DMEM_MULT);
    endfunction

endpackage

`default_nettype wire

// File: verif/clk_gen.sv
`default_nettype none

module clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_N
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        rst_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_N = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/lsu_tb.sv
`default_nettype none

module lsu_tb import core_pkg::*, mem_pkg::*; ();

    localparam int TIMEOUT = 500;

    logic        clk_in;
    logic        rst_N_in;
    logic        flush_in;
    rob_issue_t  issue_in;
    logic        issue_credit;
    reg_write_t  reg_wr_out;

    reg_write_t  exp_q [$];
    int          credits;
    int          errors;
    int          wb_count;
    int          stall_cycles;
    int          test_num;
    int          tests_failed;
    logic [31:0] rng;

    clk_gen #(
        .PERIOD       (20),
        .RESET_CYCLES (2)
    ) u_clk_gen (
        .clk   (clk_in),
        .rst_N (rst_N_in)
    );

    lsu_top DUT (
        .clk_in       (clk_in),
        .rst_N_in     (rst_N_in),
        .flush_in     (flush_in),
        .issue_in     (issue_in),
        .issue_credit (issue_credit),
        .reg_wr_out   (reg_wr_out)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected bank word from the word index times the golden-ratio constant
    function automatic logic [WORD_SIZE-1:0] ref_load(input logic [WORD_SIZE-1:0] addr);
        logic [31:0] idx;
        idx = {24'd0, addr[9:2]};
        return idx * 32'h9E3779B9;
    endfunction

    task automatic stall_fail(input string what);
        $display("timeout: %s after %0d cycles", what, TIMEOUT);
        $display("Verification failed");
        $finish;
    endtask

    task automatic tick();
        @(posedge clk_in);
        #2;
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        while (!rst_N_in) begin
            if (waited >= TIMEOUT) stall_fail("reset never released");
            waited++;
            tick();
        end
    endtask

    task automatic send_uop(input uopcode_t op, input logic [31:0] r1, input logic [31:0] r2,
                            input preg_t dest);
        int waited;
        waited = 0;
        while (credits == 0) begin
            if (waited >= TIMEOUT) stall_fail("no issue credit came back");
            stall_cycles++;
            waited++;
            tick();
        end
        issue_in.valid         = 1'b1;
        issue_in.uopcode       = op;
        issue_in.r1_val        = r1;
        issue_in.r2_val        = r2;
        issue_in.dest_reg_phys = dest;
        credits--;
        if (op == UOP_LOAD) begin
            exp_q.push_back({1'b1, dest, ref_load(r1 + r2)});
        end
        tick();
        issue_in = '0;
    endtask

    // Both operands word aligned so their sum stays below 1024
    task automatic send_rand(input uopcode_t op);
        logic [31:0] r1;
        logic [31:0] r2;
        rng = xorshift(rng);
        r1  = rng & 32'h1FC;
        rng = xorshift(rng);
        r2  = rng & 32'h1FC;
        rng = xorshift(rng);
        send_uop(op, r1, r2, preg_t'(rng[5:0]));
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || credits != ISSUE_DEPTH) begin
            if (waited >= TIMEOUT) stall_fail("loads or issue credits still outstanding");
            waited++;
            tick();
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("%s: expected %0d, saw %0d", what, exp, got);
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        test_num++;
        if (errors == err_start) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_num, name, errors - err_start);
        end
    endtask

    // Credit returns seen by the producer
    always @(negedge clk_in) begin
        if (rst_N_in && issue_credit) begin
            credits++;
            assert (credits <= ISSUE_DEPTH) else begin
                errors++;
                $display("issue credit returned beyond the %0d the producer owns", ISSUE_DEPTH);
            end
        end
    end

    // Write-backs come back in issue order
    always @(negedge clk_in) begin
        reg_write_t exp;
        if (rst_N_in && reg_wr_out.en) begin
            wb_count++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("write-back to register %h with no load outstanding", reg_wr_out.index);
            end
            if (exp_q.size() != 0) begin
                exp = exp_q.pop_front();
                assert (reg_wr_out.index == exp.index) else begin
                    errors++;
                    $display("mismatch reg_wr_out.index: expected %h, got %h",
                             exp.index, reg_wr_out.index);
                end
                assert (reg_wr_out.data == exp.data) else begin
                    errors++;
                    $display("mismatch reg_wr_out.data: expected %h, got %h",
                             exp.data, reg_wr_out.data);
                end
            end
        end
    end

    initial begin
        int err_start;
        int wb_start;
        int stall_start;
        issue_in     = '0;
        flush_in     = 1'b0;
        credits      = ISSUE_DEPTH;
        errors       = 0;
        wb_count     = 0;
        stall_cycles = 0;
        test_num     = 0;
        tests_failed = 0;
        rng          = 32'd52;
        wait_reset();
        tick();

        err_start = errors;
        wb_start  = wb_count;
        send_uop(UOP_LOAD, 32'h40, 32'h24, 6'd5);
        wait_idle();
        // Quiet window to catch a repeated write-back
        repeat (10) tick();
        check_count("single load write-backs", wb_count - wb_start, 1);
        end_test("single load", err_start);

        err_start = errors;
        wb_start  = wb_count;
        for (int i = 0; i < 40; i++) begin
            send_rand(UOP_LOAD);
        end
        wait_idle();
        check_count("burst write-backs", wb_count - wb_start, 40);
        end_test("random burst", err_start);

        err_start = errors;
        wb_start  = wb_count;
        for (int i = 0; i < 16; i++) begin
            if (i % 2 == 0) begin
                send_rand(UOP_LOAD);
            end else begin
                send_rand(uopcode_t'(2'd1 + 2'((i / 2) % 3)));
            end
        end
        wait_idle();
        check_count("mixed uop write-backs", wb_count - wb_start, 8);
        end_test("non-load uops", err_start);

        err_start   = errors;
        wb_start    = wb_count;
        stall_start = stall_cycles;
        for (int i = 0; i < 2 * LQ_SIZE + 4; i++) begin
            send_rand(UOP_LOAD);
        end
        wait_idle();
        assert (stall_cycles > stall_start) else begin
            errors++;
            $display("producer never ran out of issue credits under back-pressure");
        end
        check_count("back-pressure write-backs", wb_count - wb_start, 2 * LQ_SIZE + 4);
        end_test("back-pressure", err_start);

        err_start = errors;
        for (int i = 0; i < 6; i++) begin
            send_rand(UOP_LOAD);
        end
        flush_in = 1'b1;
        credits  = ISSUE_DEPTH;
        exp_q.delete();
        tick();
        flush_in = 1'b0;
        wb_start = wb_count;
        repeat (8) tick();
        check_count("write-backs after flush", wb_count - wb_start, 0);
        check_count("issue credits after flush", credits, ISSUE_DEPTH);
        wb_start = wb_count;
        for (int i = 0; i < 10; i++) begin
            send_rand(UOP_LOAD);
        end
        wait_idle();
        check_count("write-backs after refill", wb_count - wb_start, 10);
        end_test("flush", err_start);

        $display("%0d tests, %0d failed, %0d write-backs, %0d errors",
                 test_num, tests_failed, wb_count, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
